// ==== design/dht_cfg.svh ====
//--------------------
// Sizes for the Huffman table decoder
// Memory depth and pointer width must agree
//--------------------
`ifndef DHT_CFG_SVH
`define DHT_CFG_SVH

// Four tables, luma and chroma, DC and AC
`define DHT_NUM_TABLES 4
// Code lengths 1 to 16
`define DHT_MAX_LEN 16
`define DHT_CODE_W 16
// Shared symbol store for all tables
`define DHT_RAM_DEPTH 1024
`define DHT_PTR_W 10
`define DHT_SYM_W 8

`endif

// ==== design/dht_stream_pkg.sv ====
//--------------------
// External byte stream and lookup port records
// Lookup window is left aligned, MSB first
//--------------------
`include "dht_cfg.svh"

package dht_stream_pkg;

    // One DHT segment byte
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;
    } cfg_beat_t;

    // Lookup request, tbl uses the table_sel_t encoding
    typedef struct packed {
        logic                   valid;
        logic [1:0]             tbl;
        logic [`DHT_CODE_W-1:0] bits;
    } lookup_req_t;

    // Lookup response, width is the code length 1 to 16
    typedef struct packed {
        logic                                valid;
        logic [$clog2(`DHT_MAX_LEN):0]       width;
        logic [`DHT_SYM_W-1:0]               value;
    } lookup_rsp_t;

endpackage

// ==== design/dht_table_pkg.sv ====
//--------------------
// Internal table records shared by parser,
// bounds store and symbol memory
//--------------------
`include "dht_cfg.svh"

package dht_table_pkg;

    typedef enum logic [1:0] {
        TBL_LUMA_DC   = 2'd0,
        TBL_LUMA_AC   = 2'd1,
        TBL_CHROMA_DC = 2'd2,
        TBL_CHROMA_AC = 2'd3
    } table_sel_t;

    // Canonical bounds of one code length
    // max_code is exclusive
    typedef struct packed {
        logic [`DHT_CODE_W-1:0] min_code;
        logic [`DHT_CODE_W-1:0] max_code;
        logic [`DHT_PTR_W-1:0]  ptr;
    } code_bound_t;

    // len_idx 0 means length 1
    typedef struct packed {
        logic                            valid;
        table_sel_t                      tbl;
        logic [$clog2(`DHT_MAX_LEN)-1:0] len_idx;
        code_bound_t                     bound;
    } bound_wr_t;

    typedef struct packed {
        logic                  valid;
        logic [`DHT_PTR_W-1:0] addr;
        logic [`DHT_SYM_W-1:0] data;
    } sym_wr_t;

    // Stage one result towards the symbol memory
    typedef struct packed {
        logic                          valid;
        logic [`DHT_PTR_W-1:0]         addr;
        logic [$clog2(`DHT_MAX_LEN):0] width;
    } sym_rd_t;

endpackage

// ==== design/dht_segment_parser.sv ====
//--------------------
// DHT segment walker, one byte per cycle
// Write pointer only clears on reset, so each table loads once
// and all tables share 1024 symbol slots
//--------------------
`timescale 1ns/1ns
`include "dht_cfg.svh"

module dht_segment_parser
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  dht_stream_pkg::cfg_beat_t cfg_i,
    output logic                      cfg_accept_o,
    output dht_table_pkg::bound_wr_t  bound_wr_o,
    output dht_table_pkg::sym_wr_t    sym_wr_o
);

    typedef enum logic [1:0] {
        PH_TABLE,
        PH_COUNT,
        PH_SYMBOL
    } phase_t;

    phase_t                    phase_q;
    logic [3:0]                cnt_idx_q;
    logic [7:0]                counts_q [`DHT_MAX_LEN];
    logic [`DHT_MAX_LEN-1:0]   nonempty_q;
    logic [11:0]               total_q;
    logic [11:0]               sym_cnt_q;
    logic [3:0]                len_q;
    logic [7:0]                pos_q;
    logic [`DHT_CODE_W-1:0]    code_q;
    logic [`DHT_PTR_W-1:0]     wr_ptr_q;
    dht_table_pkg::table_sel_t tbl_q;

    logic        in_sym_w;
    logic        xfer_w;
    logic        sym_xfer_w;
    logic        len_done_w;
    logic        seg_done_w;
    logic [11:0] total_next_w;

    // Accept stalls only on an empty length in the symbol phase
    assign in_sym_w     = (phase_q == PH_SYMBOL);
    assign cfg_accept_o = !in_sym_w || nonempty_q[len_q];
    assign xfer_w       = cfg_i.valid && cfg_accept_o;
    assign sym_xfer_w   = xfer_w && in_sym_w;
    assign len_done_w   = (pos_q + 8'd1 == counts_q[len_q]);
    assign seg_done_w   = sym_xfer_w && (sym_cnt_q + 12'd1 == total_q);
    assign total_next_w = total_q + {4'b0, cfg_i.data};

    //--------------------
    // Segment walk
    //--------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            phase_q    <= PH_TABLE;
            cnt_idx_q  <= '0;
            nonempty_q <= '0;
            total_q    <= '0;
            sym_cnt_q  <= '0;
            len_q      <= '0;
            pos_q      <= '0;
            code_q     <= '0;
            wr_ptr_q   <= '0;
        end
        else
        begin
            if (sym_xfer_w)
                wr_ptr_q <= wr_ptr_q + 1'b1;

            case (phase_q)
                PH_TABLE:
                begin
                    if (xfer_w)
                    begin
                        cnt_idx_q <= '0;
                        total_q   <= '0;
                        sym_cnt_q <= '0;
                        len_q     <= '0;
                        pos_q     <= '0;
                        code_q    <= '0;
                        phase_q   <= PH_COUNT;
                    end
                end
                PH_COUNT:
                begin
                    if (xfer_w)
                    begin
                        nonempty_q[cnt_idx_q] <= (cfg_i.data != 8'd0);
                        total_q               <= total_next_w;
                        cnt_idx_q             <= cnt_idx_q + 4'd1;
                        // A table with no symbols ends after its counts
                        if (cnt_idx_q == 4'(`DHT_MAX_LEN - 1))
                            phase_q <= (total_next_w == 12'd0) ? PH_TABLE : PH_SYMBOL;
                    end
                end
                default:
                begin
                    if (sym_xfer_w)
                    begin
                        sym_cnt_q <= sym_cnt_q + 12'd1;
                        if (len_done_w)
                        begin
                            pos_q  <= '0;
                            len_q  <= len_q + 4'd1;
                            code_q <= (code_q + 1'b1) << 1;
                        end
                        else
                        begin
                            pos_q  <= pos_q + 8'd1;
                            code_q <= code_q + 1'b1;
                        end
                    end
                    else if (cfg_i.valid)
                    begin
                        // Skip an empty length, one stall cycle
                        len_q  <= len_q + 4'd1;
                        code_q <= code_q << 1;
                    end
                end
            endcase

            if (xfer_w && (cfg_i.last || seg_done_w))
                phase_q <= PH_TABLE;
        end
    end

    // Table byte and counts
    always_ff @(posedge clk_i)
    begin
        if (xfer_w && phase_q == PH_TABLE)
            tbl_q <= dht_table_pkg::table_sel_t'({cfg_i.data[0], cfg_i.data[4]});
        if (xfer_w && phase_q == PH_COUNT)
            counts_q[cnt_idx_q] <= cfg_i.data;
    end

    //--------------------
    // Write strobes
    //--------------------
    always_comb
    begin
        bound_wr_o.valid          = sym_xfer_w && (pos_q == 8'd0);
        bound_wr_o.tbl            = tbl_q;
        bound_wr_o.len_idx        = len_q;
        bound_wr_o.bound.min_code = code_q;
        bound_wr_o.bound.max_code = code_q + {{(`DHT_CODE_W - 8){1'b0}}, counts_q[len_q]};
        bound_wr_o.bound.ptr      = wr_ptr_q;

        sym_wr_o.valid = sym_xfer_w;
        sym_wr_o.addr  = wr_ptr_q;
        sym_wr_o.data  = cfg_i.data;
    end

endmodule

// ==== design/dht_code_bounds.sv ====
//--------------------
// Code bounds of all tables and lookup stage one
// Lookups into an unloaded table give undefined results
//--------------------
`timescale 1ns/1ns
`include "dht_cfg.svh"

module dht_code_bounds
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  dht_table_pkg::bound_wr_t    bound_wr_i,
    input  dht_stream_pkg::lookup_req_t lookup_req_i,
    output dht_table_pkg::sym_rd_t      rd_o
);

    localparam int LEN_IDX_W = $clog2(`DHT_MAX_LEN);

    dht_table_pkg::code_bound_t bounds_q [`DHT_NUM_TABLES][`DHT_MAX_LEN];

    logic [LEN_IDX_W-1:0]   len_idx_w;
    logic                   valid_q;
    logic [1:0]             tbl_q;
    logic [LEN_IDX_W-1:0]   len_q;
    logic [`DHT_CODE_W-1:0] bits_q;

    dht_table_pkg::code_bound_t sel_w;
    logic [`DHT_CODE_W-1:0]     code_w;
    logic [`DHT_CODE_W-1:0]     ptr_ext_w;
    logic [`DHT_CODE_W-1:0]     addr_full_w;

    //--------------------
    // Bounds store
    //--------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int t = 0; t < `DHT_NUM_TABLES; t++)
            begin
                for (int l = 0; l < `DHT_MAX_LEN; l++)
                    bounds_q[t][l] <= '0;
            end
        end
        else if (bound_wr_i.valid)
        begin
            bounds_q[bound_wr_i.tbl][bound_wr_i.len_idx] <= bound_wr_i.bound;
        end
    end

    //--------------------
    // Stage one, shortest matching length
    //--------------------
    always_comb
    begin : len_search
        logic [`DHT_CODE_W-1:0] prefix;
        len_idx_w = LEN_IDX_W'(`DHT_MAX_LEN - 1);
        // Walk downwards so the shortest match wins
        for (int i = `DHT_MAX_LEN - 2; i >= 0; i--)
        begin
            prefix = lookup_req_i.bits >> (`DHT_CODE_W - 1 - i);
            if (prefix < bounds_q[lookup_req_i.tbl][i].max_code)
                len_idx_w = LEN_IDX_W'(i);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            valid_q <= 1'b0;
        else
            valid_q <= lookup_req_i.valid;
    end

    // Window travels with the request
    always_ff @(posedge clk_i)
    begin
        tbl_q  <= lookup_req_i.tbl;
        len_q  <= len_idx_w;
        bits_q <= lookup_req_i.bits;
    end

    //--------------------
    // Symbol address
    //--------------------
    assign sel_w       = bounds_q[tbl_q][len_q];
    assign code_w      = bits_q >> (`DHT_CODE_W - 1 - len_q);
    assign ptr_ext_w   = {{(`DHT_CODE_W - `DHT_PTR_W){1'b0}}, sel_w.ptr};
    assign addr_full_w = code_w - sel_w.min_code + ptr_ext_w;

    always_comb
    begin
        rd_o.valid = valid_q;
        rd_o.addr  = addr_full_w[`DHT_PTR_W-1:0];
        rd_o.width = {1'b0, len_q} + 5'd1;
    end

endmodule

// ==== design/dht_symbol_ram.sv ====
//--------------------
// 1024 x 8 symbol store, synchronous read
// Separate write and read ports
//--------------------
`timescale 1ns/1ns
`include "dht_cfg.svh"

module dht_symbol_ram
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  dht_table_pkg::sym_wr_t      sym_wr_i,
    input  dht_table_pkg::sym_rd_t      rd_i,
    output dht_stream_pkg::lookup_rsp_t lookup_rsp_o
);

    logic [`DHT_SYM_W-1:0]         mem_q [`DHT_RAM_DEPTH];
    logic [`DHT_SYM_W-1:0]         value_q;
    logic [$clog2(`DHT_MAX_LEN):0] width_q;
    logic                          valid_q;

    // Write port from the parser, read port every cycle
    always_ff @(posedge clk_i)
    begin
        if (sym_wr_i.valid)
            mem_q[sym_wr_i.addr] <= sym_wr_i.data;
        value_q <= mem_q[rd_i.addr];
        width_q <= rd_i.width;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            valid_q <= 1'b0;
        else
            valid_q <= rd_i.valid;
    end

    always_comb
    begin
        lookup_rsp_o.valid = valid_q;
        lookup_rsp_o.width = width_q;
        lookup_rsp_o.value = value_q;
    end

endmodule

// ==== design/dht_decoder.sv ====
//--------------------
// JPEG Huffman decoder top, run-time DHT load
// Lookup latency two cycles, one request per cycle
//--------------------
`timescale 1ns/1ns
`include "dht_cfg.svh"

module dht_decoder
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  dht_stream_pkg::cfg_beat_t   cfg_i,
    output logic                        cfg_accept_o,
    input  dht_stream_pkg::lookup_req_t lookup_req_i,
    output dht_stream_pkg::lookup_rsp_t lookup_rsp_o
);

    dht_table_pkg::bound_wr_t bound_wr_w;
    dht_table_pkg::sym_wr_t   sym_wr_w;
    dht_table_pkg::sym_rd_t   sym_rd_w;

    dht_segment_parser u_parser
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cfg_i        (cfg_i),
        .cfg_accept_o (cfg_accept_o),
        .bound_wr_o   (bound_wr_w),
        .sym_wr_o     (sym_wr_w)
    );

    // Stage one
    dht_code_bounds u_bounds
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bound_wr_i   (bound_wr_w),
        .lookup_req_i (lookup_req_i),
        .rd_o         (sym_rd_w)
    );

    // Stage two and response register
    dht_symbol_ram u_ram
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .sym_wr_i     (sym_wr_w),
        .rd_i         (sym_rd_w),
        .lookup_rsp_o (lookup_rsp_o)
    );

endmodule

// ==== sim/dht_tb.sv ====
//--------------------
// Loads the four DHT tables once in a single stream
// Luma DC uses the standard counts and the other tables random ones
//--------------------
`timescale 1ns/1ns
`include "dht_cfg.svh"

module dht_tb;

    localparam int CLK_PERIOD = 20;
    localparam int N_PIPE     = 200;
    localparam int N_GAP      = 100;
    localparam int LUMA_DC_COUNTS [16] = '{0, 1, 5, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0};

    typedef struct packed {
        logic [31:0]                 due;
        dht_stream_pkg::lookup_rsp_t rsp;
    } expect_t;

    logic                        clk_i;
    logic                        rst_i;
    dht_stream_pkg::cfg_beat_t   cfg_i;
    logic                        cfg_accept_o;
    dht_stream_pkg::lookup_req_t lookup_req_i;
    dht_stream_pkg::lookup_rsp_t lookup_rsp_o;

    logic [31:0] lfsr;
    int          counts [`DHT_NUM_TABLES][`DHT_MAX_LEN];
    logic [7:0]  syms [`DHT_NUM_TABLES][256];
    int          nsym [`DHT_NUM_TABLES];
    expect_t     exp_q [$];
    expect_t     got;
    int          cycle;
    time         limit_ns;
    string       test_name;

    dht_decoder dut_i
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cfg_i        (cfg_i),
        .cfg_accept_o (cfg_accept_o),
        .lookup_req_i (lookup_req_i),
        .lookup_rsp_o (lookup_rsp_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial
    begin
        cycle = 0;
    end

    always @(posedge clk_i)
    begin
        cycle <= cycle + 1;
    end

    //--------------------
    // Error handling and checks
    //--------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
            stop_on_error($sformatf("Fail %s expected %0h actual %0h", name, expected, actual));
    endtask

    //--------------------
    // Random numbers
    //--------------------
    function automatic logic [31:0] galois_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One LFSR step per bit
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = galois_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    //--------------------
    // Table contents
    //--------------------
    task automatic build_tables();
        int  lead;
        int  avail;
        int  c;
        int  s;
        bit  used [256];
        nsym[0] = 12;
        for (int l = 0; l < `DHT_MAX_LEN; l++)
            counts[0][l] = LUMA_DC_COUNTS[l];
        for (int k = 0; k < 12; k++)
            syms[0][k] = 8'(k);
        for (int t = 1; t < `DHT_NUM_TABLES; t++)
        begin
            lead  = 1 + rand_bits(1);
            avail = 1;
            nsym[t] = 0;
            // Leading empty lengths and an inner empty length at lead+2
            // One code slot always kept free
            for (int l = 1; l <= `DHT_MAX_LEN; l++)
            begin
                avail = avail * 2;
                c = 0;
                if (l > lead && l != lead + 2 && l <= 12)
                begin
                    c = rand_bits(3);
                    if (c == 0 && (l == lead + 1 || l == lead + 3))
                        c = 1;
                    if (c > avail - 1)
                        c = avail - 1;
                end
                counts[t][l-1] = c;
                avail   = avail - c;
                nsym[t] = nsym[t] + c;
            end
            for (int i = 0; i < 256; i++)
                used[i] = 1'b0;
            for (int k = 0; k < nsym[t]; k++)
            begin
                s = rand_bits(8);
                while (used[s])
                    s = rand_bits(8);
                used[s]    = 1'b1;
                syms[t][k] = 8'(s);
            end
        end
    endtask

    function automatic int expected_stalls(input int t);
        int longest;
        int n;
        longest = 0;
        n = 0;
        for (int l = 0; l < `DHT_MAX_LEN; l++)
            if (counts[t][l] != 0)
                longest = l;
        for (int l = 0; l < longest; l++)
            if (counts[t][l] == 0)
                n++;
        return n;
    endfunction

    // Canonical code of symbol k with random filler behind it
    function automatic logic [15:0] build_window(input int t, input int k);
        int code;
        int base;
        int len;
        int fill;
        code = 0;
        base = 0;
        len  = 0;
        for (int l = 1; l <= `DHT_MAX_LEN && len == 0; l++)
        begin
            if (k < base + counts[t][l-1])
            begin
                len  = l;
                code = code + k - base;
            end
            else
            begin
                code = (code + counts[t][l-1]) << 1;
                base = base + counts[t][l-1];
            end
        end
        fill = rand_bits(16 - len);
        return 16'((code << (16 - len)) | fill);
    endfunction

    // Reference model picks the first length whose code range holds the prefix
    function automatic dht_stream_pkg::lookup_rsp_t decode_ref(input int t,
                                                               input logic [15:0] window);
        dht_stream_pkg::lookup_rsp_t rsp;
        int code;
        int base;
        int top;
        rsp  = '0;
        code = 0;
        base = 0;
        for (int l = 1; l <= `DHT_MAX_LEN; l++)
        begin
            top = int'(window >> (16 - l));
            if (!rsp.valid && top >= code && top < code + counts[t][l-1])
            begin
                rsp.valid = 1'b1;
                rsp.width = 5'(l);
                rsp.value = syms[t][base + top - code];
            end
            code = (code + counts[t][l-1]) << 1;
            base = base + counts[t][l-1];
        end
        return rsp;
    endfunction

    //--------------------
    // Stimulus tasks run on the falling edge
    //--------------------
    task automatic send_byte(input logic [7:0] data, input logic last, inout int stalls);
        cfg_i.valid = 1'b1;
        cfg_i.data  = data;
        cfg_i.last  = last;
        while (!cfg_accept_o)
        begin
            stalls++;
            @(negedge clk_i);
        end
        @(negedge clk_i);
    endtask

    task automatic send_segment(input int t);
        int         stalls;
        logic       last_seg;
        logic [1:0] ti;
        stalls   = 0;
        ti       = 2'(t);
        last_seg = (t == `DHT_NUM_TABLES - 1);
        // Table index bit 0 sits in byte bit 4
        send_byte({3'b000, ti[0], 3'b000, ti[1]}, 1'b0, stalls);
        for (int l = 0; l < `DHT_MAX_LEN; l++)
            send_byte(8'(counts[t][l]), 1'b0, stalls);
        for (int k = 0; k < nsym[t]; k++)
            send_byte(syms[t][k], last_seg && (k == nsym[t] - 1), stalls);
        check($sformatf("load stalls table %0d", t), expected_stalls(t), stalls);
    endtask

    task automatic issue_lookup(input int t, input logic [15:0] window);
        expect_t e;
        lookup_req_i.valid = 1'b1;
        lookup_req_i.tbl   = 2'(t);
        lookup_req_i.bits  = window;
        e.due = 32'(cycle + 2);
        e.rsp = decode_ref(t, window);
        exp_q.push_back(e);
        @(negedge clk_i);
    endtask

    task automatic idle(input int n);
        lookup_req_i.valid = 1'b0;
        repeat (n) @(negedge clk_i);
    endtask

    task automatic drain();
        lookup_req_i.valid = 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk_i);
    endtask

    //--------------------
    // Response comparator
    //--------------------
    always @(negedge clk_i)
    begin
        if (!rst_i)
        begin
            if (lookup_rsp_o.valid)
            begin
                if (exp_q.size() == 0)
                begin
                    stop_on_error("A lookup response arrived with no request pending");
                end
                else
                begin
                    got = exp_q.pop_front();
                    check({test_name, " latency"}, got.due, 32'(cycle));
                    check({test_name, " width"}, 32'(got.rsp.width), 32'(lookup_rsp_o.width));
                    check({test_name, " value"}, 32'(got.rsp.value), 32'(lookup_rsp_o.value));
                end
            end
            else if (exp_q.size() != 0 && int'(exp_q[0].due) < cycle)
            begin
                stop_on_error("A lookup response did not arrive two cycles after its request");
            end
        end
    end

    initial
    begin : watchdog
        wait (limit_ns != 0);
        #(limit_ns);
        stop_on_error("Timeout, the run took longer than its tests allow");
    end

    initial
    begin : main
        int t;
        int k;
        int work;
        lfsr         = 32'h46af;
        rst_i        = 1'b1;
        cfg_i        = '0;
        lookup_req_i = '0;
        test_name    = "reset";
        build_tables();

        // Bytes, stall cycles and lookups
        work = 0;
        for (int i = 0; i < `DHT_NUM_TABLES; i++)
            work = work + 17 + nsym[i] + expected_stalls(i) + nsym[i];
        work     = work + N_PIPE + N_GAP;
        limit_ns = time'(4 * CLK_PERIOD * work + 8 * CLK_PERIOD);

        repeat (8) @(negedge clk_i);
        rst_i = 1'b0;
        repeat (4)
        begin
            check("reset accept", 1, 32'(cfg_accept_o));
            check("reset response valid", 0, 32'(lookup_rsp_o.valid));
            @(negedge clk_i);
        end

        test_name = "load";
        for (int i = 0; i < `DHT_NUM_TABLES; i++)
            send_segment(i);
        cfg_i = '0;

        test_name = "single";
        for (int i = 0; i < `DHT_NUM_TABLES; i++)
        begin
            for (int j = 0; j < nsym[i]; j++)
            begin
                issue_lookup(i, build_window(i, j));
                drain();
            end
        end

        test_name = "pipelined";
        repeat (N_PIPE)
        begin
            t = rand_bits(2);
            k = rand_bits(8) % nsym[t];
            issue_lookup(t, build_window(t, k));
        end
        drain();

        test_name = "idle gaps";
        repeat (N_GAP)
        begin
            t = rand_bits(2);
            k = rand_bits(8) % nsym[t];
            issue_lookup(t, build_window(t, k));
            idle(rand_bits(2));
        end
        drain();
        idle(4);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== dht_decoder.f ====
+incdir+design
design/dht_stream_pkg.sv
design/dht_table_pkg.sv
design/dht_segment_parser.sv
design/dht_code_bounds.sv
design/dht_symbol_ram.sv
design/dht_decoder.sv
sim/dht_tb.sv

// ==== Makefile ====
# Verilator build and run for the DHT decoder testbench
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := dht_tb
FILELIST := dht_decoder.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) design/dht_cfg.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
